// File: verilog/rsa_pkg.sv
package rsa_pkg;

    // Operand geometry
    localparam int KEY_BITS  = 256;
    localparam int KEY_BYTES = KEY_BITS / 8;

    typedef logic [KEY_BITS-1:0] key_t;
    typedef logic [7:0]          byte_t;
    typedef logic [4:0]          avm_addr_t;
    typedef logic [31:0]         avm_data_t;
    typedef logic [5:0]          byte_cnt_t;
    // Counts 0 to KEY_BITS inclusive
    typedef logic [8:0]          bit_cnt_t;

    // Peripheral register map, word addresses
    localparam avm_addr_t RX_BASE     = 5'd0;
    localparam avm_addr_t TX_BASE     = 5'd4;
    localparam avm_addr_t STATUS_BASE = 5'd8;

    // Status register bits
    localparam int TX_OK_BIT = 6;
    localparam int RX_OK_BIT = 7;

endpackage

// File: verilog/rsa_if.sv
`timescale 1ns/1ps

// Montgomery product request
interface mont_if;
    import rsa_pkg::*;

    logic req;
    logic ack;
    key_t x;
    key_t y;
    key_t n;
    key_t prod;

    modport requester (output req, output x, output y, output n, input ack, input prod);
    modport responder (input req, input x, input y, input n, output ack, output prod);
endinterface

// Conversion into the Montgomery domain
interface prescale_if;
    import rsa_pkg::*;

    logic req;
    logic ack;
    key_t a;
    key_t n;
    key_t scaled;

    modport requester (output req, output a, output n, input ack, input scaled);
    modport responder (input req, input a, input n, output ack, output scaled);
endinterface

// Full modular exponentiation
interface core_if;
    import rsa_pkg::*;

    logic req;
    logic ack;
    key_t a;
    key_t d;
    key_t n;
    key_t result;

    modport requester (output req, output a, output d, output n, input ack, input result);
    modport responder (input req, input a, input d, input n, output ack, output result);
endinterface

// File: verilog/mont_mult.sv
`timescale 1ns/1ps

module mont_mult (
    input logic       avm_clk,
    input logic       avm_rst,
    mont_if.responder mif
);
    import rsa_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

    state_t              state;
    bit_cnt_t            cnt;
    key_t                x_sh;
    key_t                prod_r;
    logic [KEY_BITS:0]   acc;
    logic [KEY_BITS:0]   acc_sub;
    logic [KEY_BITS+1:0] sum;
    logic [KEY_BITS+1:0] sum_even;

    // acc stays below 2n, so the sums fit in KEY_BITS+2 bits
    always_comb begin
        sum      = {1'b0, acc} + (x_sh[0] ? {2'b0, mif.y} : '0);
        sum_even = sum[0] ? sum + {2'b0, mif.n} : sum;
        acc_sub  = acc - {1'b0, mif.n};
    end

    assign mif.ack  = (state == DONE);
    assign mif.prod = prod_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (mif.req) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    if (cnt == bit_cnt_t'(KEY_BITS)) begin
                        state <= DONE;
                    end
                    cnt <= cnt + 1'b1;
                end
                DONE: begin
                    if (!mif.req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == IDLE && mif.req) begin
            acc  <= '0;
            x_sh <= mif.x;
        end else if (state == RUN) begin
            if (cnt == bit_cnt_t'(KEY_BITS)) begin
                // Last pass brings the value below n
                prod_r <= (acc >= {1'b0, mif.n}) ? acc_sub[KEY_BITS-1:0]
                                                 : acc[KEY_BITS-1:0];
            end else begin
                acc  <= sum_even[KEY_BITS+1:1];
                x_sh <= x_sh >> 1;
            end
        end
    end

    assert property (@(posedge avm_clk) disable iff (avm_rst)
        mif.req && !mif.ack |=> $stable(mif.x) && $stable(mif.y) && $stable(mif.n))
        else $error("mont_mult operands changed during a request");

    assert property (@(posedge avm_clk) disable iff (avm_rst)
        mif.req && !mif.ack |=> mif.req)
        else $error("mont_mult req dropped before ack");

endmodule

// File: verilog/mod_prescale.sv
`timescale 1ns/1ps

module mod_prescale (
    input logic           avm_clk,
    input logic           avm_rst,
    prescale_if.responder pif
);
    import rsa_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

    state_t            state;
    bit_cnt_t          cnt;
    key_t              r;
    key_t              scaled_r;
    logic [KEY_BITS:0] dbl;
    logic [KEY_BITS:0] dbl_red;

    // Doubling of a value below n needs at most one subtraction
    assign dbl     = {r, 1'b0};
    assign dbl_red = (dbl >= {1'b0, pif.n}) ? dbl - {1'b0, pif.n} : dbl;

    assign pif.ack    = (state == DONE);
    assign pif.scaled = scaled_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pif.req) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    if (cnt == bit_cnt_t'(KEY_BITS)) begin
                        state <= DONE;
                    end
                    cnt <= cnt + 1'b1;
                end
                DONE: begin
                    if (!pif.req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == IDLE && pif.req) begin
            r <= pif.a;
        end else if (state == RUN) begin
            if (cnt == bit_cnt_t'(KEY_BITS)) begin
                scaled_r <= r;
            end else begin
                r <= dbl_red[KEY_BITS-1:0];
            end
        end
    end

    assert property (@(posedge avm_clk) disable iff (avm_rst)
        pif.req && !pif.ack |=> pif.req)
        else $error("mod_prescale req dropped before ack");

endmodule

// File: verilog/rsa_core.sv
`timescale 1ns/1ps

module rsa_core (
    input logic           avm_clk,
    input logic           avm_rst,
    core_if.responder     cif,
    prescale_if.requester pif,
    mont_if.requester     sq_if,
    mont_if.requester     mul_if
);
    import rsa_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PRESCALE,
        ROUND_REQ,
        ROUND_WAIT,
        ROUND_DROP,
        DONE
    } state_t;

    state_t   state;
    logic     pre_req;
    logic     unit_req;
    logic     both_ack;
    logic     none_ack;
    bit_cnt_t rnd;
    key_t     t;
    key_t     m;
    key_t     d_sh;

    assign both_ack = sq_if.ack && mul_if.ack;
    assign none_ack = !sq_if.ack && !mul_if.ack;

    assign pif.req = pre_req;
    assign pif.a   = cif.a;
    assign pif.n   = cif.n;

    // Square unit works on t, multiply unit folds t into m
    assign sq_if.req  = unit_req;
    assign sq_if.x    = t;
    assign sq_if.y    = t;
    assign sq_if.n    = cif.n;
    assign mul_if.req = unit_req;
    assign mul_if.x   = m;
    assign mul_if.y   = t;
    assign mul_if.n   = cif.n;

    assign cif.ack    = (state == DONE);
    assign cif.result = m;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= IDLE;
            pre_req  <= 1'b0;
            unit_req <= 1'b0;
            rnd      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cif.req) begin
                        pre_req <= 1'b1;
                        rnd     <= '0;
                        state   <= PRESCALE;
                    end
                end
                PRESCALE: begin
                    if (pif.ack) begin
                        pre_req <= 1'b0;
                        state   <= ROUND_REQ;
                    end
                end
                ROUND_REQ: begin
                    if (none_ack) begin
                        unit_req <= 1'b1;
                        state    <= ROUND_WAIT;
                    end
                end
                ROUND_WAIT: begin
                    if (both_ack) begin
                        unit_req <= 1'b0;
                        rnd      <= rnd + 1'b1;
                        state    <= ROUND_DROP;
                    end
                end
                ROUND_DROP: begin
                    if (none_ack) begin
                        state <= (rnd == bit_cnt_t'(KEY_BITS)) ? DONE : ROUND_REQ;
                    end
                end
                DONE: begin
                    if (!cif.req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == IDLE && cif.req) begin
            d_sh <= cif.d;
        end
        if (state == PRESCALE && pif.ack) begin
            t <= pif.scaled;
            m <= key_t'(1);
        end
        // Exponent scanned from the LSB
        if (state == ROUND_WAIT && both_ack) begin
            t <= sq_if.prod;
            if (d_sh[0]) begin
                m <= mul_if.prod;
            end
            d_sh <= d_sh >> 1;
        end
    end

    // Units may only disagree while one round is in flight
    assert property (@(posedge avm_clk) disable iff (avm_rst)
        (sq_if.ack != mul_if.ack) |-> (state == ROUND_WAIT || state == ROUND_DROP))
        else $error("square and multiply acks split across rounds");

endmodule

// File: verilog/rsa_avm_wrapper.sv
`timescale 1ns/1ps

module rsa_avm_wrapper (
    input  logic               avm_clk,
    input  logic               avm_rst,
    output rsa_pkg::avm_addr_t avm_address,
    output logic               avm_read,
    input  rsa_pkg::avm_data_t avm_readdata,
    output logic               avm_write,
    output rsa_pkg::avm_data_t avm_writedata,
    input  logic               avm_waitrequest
);
    import rsa_pkg::*;

    typedef enum logic [2:0] {GET_N, GET_D, GET_A, CALC, SEND} state_t;

    state_t    state;
    byte_cnt_t byte_cnt;
    avm_addr_t addr_r;
    logic      read_r;
    logic      write_r;
    logic      core_req;
    logic      xfer_done;
    logic      last_byte;
    byte_t     rx_byte;
    byte_t     tx_byte;
    key_t      n_r;
    key_t      d_r;
    key_t      a_r;
    key_t      res_r;

    core_if     cif();
    prescale_if pif();
    mont_if     sq_if();
    mont_if     mul_if();

    rsa_core core_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .cif     (cif),
        .pif     (pif),
        .sq_if   (sq_if),
        .mul_if  (mul_if)
    );

    mod_prescale prescale_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .pif     (pif)
    );

    mont_mult sq_unit (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .mif     (sq_if)
    );

    mont_mult mul_unit (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .mif     (mul_if)
    );

    assign cif.req = core_req;
    assign cif.a   = a_r;
    assign cif.d   = d_r;
    assign cif.n   = n_r;

    assign rx_byte       = avm_readdata[7:0];
    assign tx_byte       = res_r[KEY_BITS-1 -: 8];
    assign avm_address   = addr_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = avm_data_t'(tx_byte);

    assign xfer_done = (read_r || write_r) && !avm_waitrequest;
    assign last_byte = (byte_cnt == byte_cnt_t'(KEY_BYTES - 1));

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= GET_N;
            byte_cnt <= '0;
            addr_r   <= STATUS_BASE;
            read_r   <= 1'b0;
            write_r  <= 1'b0;
            core_req <= 1'b0;
        end else begin
            case (state)
                GET_N, GET_D, GET_A: begin
                    if (!read_r) begin
                        // First poll after reset
                        read_r <= 1'b1;
                        addr_r <= STATUS_BASE;
                    end else if (xfer_done) begin
                        if (addr_r == STATUS_BASE) begin
                            if (avm_readdata[RX_OK_BIT]) begin
                                addr_r <= RX_BASE;
                            end
                        end else begin
                            addr_r   <= STATUS_BASE;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (last_byte) begin
                                byte_cnt <= '0;
                                if (state == GET_N) begin
                                    state <= GET_D;
                                end else if (state == GET_D) begin
                                    state <= GET_A;
                                end else begin
                                    state  <= CALC;
                                    read_r <= 1'b0;
                                end
                            end
                        end
                    end
                end
                CALC: begin
                    if (!core_req && !cif.ack) begin
                        core_req <= 1'b1;
                    end else if (core_req && cif.ack) begin
                        core_req <= 1'b0;
                        state    <= SEND;
                        read_r   <= 1'b1;
                        addr_r   <= STATUS_BASE;
                    end
                end
                SEND: begin
                    if (xfer_done) begin
                        if (read_r) begin
                            if (avm_readdata[TX_OK_BIT]) begin
                                read_r  <= 1'b0;
                                write_r <= 1'b1;
                                addr_r  <= TX_BASE;
                            end
                        end else begin
                            write_r  <= 1'b0;
                            read_r   <= 1'b1;
                            addr_r   <= STATUS_BASE;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (last_byte) begin
                                byte_cnt <= '0;
                                state    <= GET_N;
                            end
                        end
                    end
                end
                default: state <= GET_N;
            endcase
        end
    end

    // Operands arrive most significant byte first
    always_ff @(posedge avm_clk) begin
        if (read_r && !avm_waitrequest && addr_r == RX_BASE) begin
            if (state == GET_N) begin
                n_r <= {n_r[KEY_BITS-9:0], rx_byte};
            end else if (state == GET_D) begin
                d_r <= {d_r[KEY_BITS-9:0], rx_byte};
            end else if (state == GET_A) begin
                a_r <= {a_r[KEY_BITS-9:0], rx_byte};
            end
        end
        if (state == CALC && core_req && cif.ack) begin
            res_r <= cif.result;
        end else if (write_r && !avm_waitrequest) begin
            res_r <= res_r << 8;
        end
    end

    assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else $error("Avalon read and write raised together");

    assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write) &&
            $stable(avm_writedata))
        else $error("Avalon request changed under waitrequest");

endmodule

// File: sim/avm_uart_model.sv
`timescale 1ns/1ps

module avm_uart_model (
    input  logic               avm_clk,
    input  logic               avm_rst,
    input  rsa_pkg::avm_addr_t avm_address,
    input  logic               avm_read,
    output rsa_pkg::avm_data_t avm_readdata,
    input  logic               avm_write,
    input  rsa_pkg::avm_data_t avm_writedata,
    output logic               avm_waitrequest,
    input  int                 stall_pct,
    output logic               tx_strobe,
    output rsa_pkg::byte_t     tx_data,
    output logic               proto_err
);
    import rsa_pkg::*;

    byte_t     rx_q[$];
    int        seed = 32'h1d70211d;
    logic      done_rd;
    logic      done_wr;
    avm_addr_t done_addr;
    avm_data_t done_data;
    logic      rx_ready;
    logic      tx_ready;

    task push_rx(input byte_t b);
        rx_q.push_back(b);
    endtask

    // Bus side updates 1 ns after each rising edge
    initial begin
        avm_waitrequest = 1'b1;
        avm_readdata    = '0;
        tx_strobe       = 1'b0;
        tx_data         = '0;
        proto_err       = 1'b0;
        done_rd         = 1'b0;
        done_wr         = 1'b0;
        done_addr       = '0;
        done_data       = '0;
        forever begin
            @(posedge avm_clk);
            #1;
            tx_strobe = 1'b0;
            if (avm_rst) begin
                avm_waitrequest = 1'b1;
                done_rd         = 1'b0;
                done_wr         = 1'b0;
            end else begin
                // Transfer accepted at the edge just passed
                if (done_rd && done_addr == RX_BASE) begin
                    if (rx_q.size() == 0) begin
                        $display("Error: RX register read while the RX queue is empty");
                        proto_err = 1'b1;
                    end else begin
                        void'(rx_q.pop_front());
                    end
                end
                if (done_wr) begin
                    if (done_addr != TX_BASE || done_data[31:8] != '0) begin
                        $display("Error: TX write with a wrong address or nonzero upper bits");
                        proto_err = 1'b1;
                    end else begin
                        tx_strobe = 1'b1;
                        tx_data   = done_data[7:0];
                    end
                end
                avm_waitrequest = ($unsigned($random(seed)) % 100) < stall_pct;
                rx_ready = (rx_q.size() != 0) && (($unsigned($random(seed)) % 100) >= stall_pct);
                tx_ready = ($unsigned($random(seed)) % 100) >= stall_pct;
                avm_readdata = '0;
                if (avm_address == STATUS_BASE) begin
                    avm_readdata[RX_OK_BIT] = rx_ready;
                    avm_readdata[TX_OK_BIT] = tx_ready;
                end else if (avm_address == RX_BASE && rx_q.size() != 0) begin
                    avm_readdata[7:0] = rx_q[0];
                end
                done_rd   = avm_read && !avm_waitrequest;
                done_wr   = avm_write && !avm_waitrequest;
                done_addr = avm_address;
                done_data = avm_writedata;
            end
        end
    end

endmodule

// File: sim/tb_rsa_wrapper.sv
`timescale 1ns/1ps

module tb_rsa_wrapper;
    import rsa_pkg::*;

    localparam int     CLK_PERIOD = 20;
    localparam int     NUM_TXNS   = 11;
    // Compute rounds plus Avalon stall allowance
    localparam longint TXN_CYCLES = 300 * 260 + 96 * 64;

    logic      avm_clk;
    logic      avm_rst;
    avm_addr_t avm_address;
    logic      avm_read;
    avm_data_t avm_readdata;
    logic      avm_write;
    avm_data_t avm_writedata;
    logic      avm_waitrequest;
    int        stall_pct;
    logic      tx_strobe;
    byte_t     tx_data;
    logic      proto_err;

    int        seed = 32'h1d70211d;
    int        err_cnt;
    int        tx_cnt;
    key_t      tx_word;
    key_t      exp_val;
    string     exp_name;
    key_t      exp_q[$];
    string     name_q[$];

    rsa_avm_wrapper dut_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    avm_uart_model uart_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .stall_pct       (stall_pct),
        .tx_strobe       (tx_strobe),
        .tx_data         (tx_data),
        .proto_err       (proto_err)
    );

    initial begin
        avm_clk = 1'b0;
        forever #(CLK_PERIOD / 2) avm_clk = ~avm_clk;
    end

    // Plain square-and-multiply from the LSB
    function automatic key_t mod_exp(input key_t base, input key_t e, input key_t n);
        logic [511:0] r;
        logic [511:0] b;
        r = 512'd1;
        b = base % n;
        for (int i = 0; i < KEY_BITS; i++) begin
            if (e[i])
                r = (r * b) % n;
            b = (b * b) % n;
        end
        return key_t'(r);
    endfunction

    function automatic key_t rand_key();
        key_t k;
        for (int i = 0; i < KEY_BITS / 32; i++)
            k[i*32 +: 32] = $random(seed);
        return k;
    endfunction

    function automatic key_t rand_modulus();
        return rand_key() | {1'b1, {(KEY_BITS - 2){1'b0}}, 1'b1};
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input key_t expected, input key_t actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic push_operand(input key_t v);
        for (int i = KEY_BYTES - 1; i >= 0; i--)
            uart_i.push_rx(v[i*8 +: 8]);
    endtask

    task automatic queue_txn(input string name, input key_t n, input key_t d, input key_t a);
        exp_q.push_back(mod_exp(a, d, n));
        name_q.push_back(name);
        push_operand(n);
        push_operand(d);
        push_operand(a);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0)
            @(posedge avm_clk);
    endtask

    // Rebuild each result from its 32 TX bytes in MSB-first order
    always @(posedge avm_clk) begin
        if (tx_strobe) begin
            if (exp_q.size() == 0) begin
                $display("Error: result byte written with no transaction pending");
                abort_run();
            end else begin
                tx_word = {tx_word[KEY_BITS-9:0], tx_data};
                tx_cnt  = tx_cnt + 1;
                if (tx_cnt == KEY_BYTES) begin
                    tx_cnt   = 0;
                    exp_val  = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    check_value(exp_name, exp_val, tx_word);
                end
            end
        end
    end

    always @(posedge proto_err) begin
        abort_run();
    end

    initial begin
        #(NUM_TXNS * TXN_CYCLES * CLK_PERIOD);
        $display("Error: timeout, the DUT did not finish all transactions in time");
        abort_run();
    end

    initial begin
        key_t n;
        key_t d;
        key_t a;
        avm_rst   = 1'b1;
        stall_pct = 20;
        err_cnt   = 0;
        tx_cnt    = 0;
        tx_word   = '0;
        repeat (5) @(posedge avm_clk);
        #1;
        avm_rst = 1'b0;

        for (int i = 0; i < 3; i++) begin
            n = rand_modulus();
            queue_txn("random_key", n, rand_key(), rand_key() % n);
            wait_results();
        end

        n = rand_modulus();
        a = rand_key() % n;
        queue_txn("exp_one_d1", n, key_t'(1), a);
        wait_results();
        queue_txn("exp_one_d2", n, key_t'(2), a);
        wait_results();

        n = rand_modulus();
        d = rand_key() | key_t'(1);
        queue_txn("zero_base_a0", n, d, '0);
        wait_results();
        queue_txn("zero_base_d0", n, '0, rand_key() % n);
        wait_results();

        // Heavy waitrequest and readiness stalls
        @(posedge avm_clk);
        #1;
        stall_pct = 75;
        for (int i = 0; i < 2; i++) begin
            n = rand_modulus();
            queue_txn("stalls", n, rand_key(), rand_key() % n);
            wait_results();
        end
        @(posedge avm_clk);
        #1;
        stall_pct = 20;

        for (int i = 0; i < 2; i++) begin
            n = rand_modulus();
            queue_txn("back_to_back", n, rand_key(), rand_key() % n);
        end
        wait_results();

        // Idle time in which a stray result byte would reach the compare process
        repeat (4 * KEY_BYTES) @(posedge avm_clk);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: compile.f
verilog/rsa_pkg.sv
verilog/rsa_if.sv
verilog/mont_mult.sv
verilog/mod_prescale.sv
verilog/rsa_core.sv
verilog/rsa_avm_wrapper.sv
sim/avm_uart_model.sv
sim/tb_rsa_wrapper.sv

// File: Bender.yml
package:
  name: rsa_avm

sources:
  - files:
      - verilog/rsa_pkg.sv
      - verilog/rsa_if.sv
      - verilog/mont_mult.sv
      - verilog/mod_prescale.sv
      - verilog/rsa_core.sv
      - verilog/rsa_avm_wrapper.sv
  - target: simulation
    files:
      - sim/avm_uart_model.sv
      - sim/tb_rsa_wrapper.sv
